// File: tb.f
hw/conv_front_pkg.sv
hw/beat_stream_if.sv
hw/beat_slice.sv
hw/axis_pixels_shift.sv
hw/weights_replay.sv
hw/lane_mult_join.sv
hw/conv_front_top.sv
dv/conv_front_tb.sv

// File: Bender.yml
package:
  name: conv_front

sources:
  # rtl in compile order
  - files:
      - hw/conv_front_pkg.sv
      - hw/beat_stream_if.sv
      - hw/beat_slice.sv
      - hw/axis_pixels_shift.sv
      - hw/weights_replay.sv
      - hw/lane_mult_join.sv
      - hw/conv_front_top.sv
  # testbench
  - target: test
    files:
      - dv/conv_front_tb.sv

// File: dv/conv_front_tb.sv
`timescale 1ns/10ps
`default_nettype none

module conv_front_tb;

  import conv_front_pkg::*;

  localparam int W        = DEF_WORD_WIDTH;
  localparam int UNITS    = DEF_UNITS;
  localparam int COPIES   = DEF_COPIES;
  localparam int REGS     = DEF_IM_SHIFT_REGS;
  localparam int BITS_SH  = shift_width(DEF_IM_SHIFT_REGS);
  localparam int NUM_JOBS = 200;
  localparam int TIMEOUT  = 1000;

  typedef logic [REGS-1:0][W-1:0]               row_t;
  typedef logic [COPIES-1:0][UNITS-1:0][W-1:0]   vec_t;
  typedef logic [COPIES-1:0][UNITS-1:0][2*W-1:0] prod_t;

  logic               aclk;
  logic               reset;
  logic               pix_valid;
  logic               pix_ready;
  row_t               pix_data;
  logic [BITS_SH-1:0] pix_shift;
  logic               pix_ones;
  logic               pix_is_max;
  logic               pix_is_lrelu;
  logic               wgt_valid;
  logic               wgt_ready;
  vec_t               wgt_data;
  logic [BITS_SH-1:0] wgt_repeat;
  logic               out_valid;
  logic               out_ready;
  prod_t              out_data;
  logic               out_is_lrelu;
  logic               out_last;

  conv_front_top conv_front_top_i (
    .aclk         (aclk),
    .reset        (reset),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .pix_data     (pix_data),
    .pix_shift    (pix_shift),
    .pix_ones     (pix_ones),
    .pix_is_max   (pix_is_max),
    .pix_is_lrelu (pix_is_lrelu),
    .wgt_valid    (wgt_valid),
    .wgt_ready    (wgt_ready),
    .wgt_data     (wgt_data),
    .wgt_repeat   (wgt_repeat),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_data     (out_data),
    .out_is_lrelu (out_is_lrelu),
    .out_last     (out_last)
  );

  always #4 aclk = ~aclk;

  // ------------------------------
  // jobs and expected beats
  // ------------------------------
  row_t  job_row   [NUM_JOBS];
  vec_t  job_wgt   [NUM_JOBS];
  int    job_shift [NUM_JOBS];
  bit    job_max   [NUM_JOBS];
  bit    job_ones  [NUM_JOBS];
  bit    job_lrelu [NUM_JOBS];
  int    job_duty  [NUM_JOBS]; // percent of cycles with out_ready high.
  int    job_pgap  [NUM_JOBS];
  int    job_wgap  [NUM_JOBS];

  prod_t exp_data  [$];
  bit    exp_lrelu [$];
  bit    exp_last  [$];
  int    exp_job   [$];

  int pix_accepted;
  int cur_job;
  int total;

  // beat k of job j built word by word from the window rules.
  function automatic prod_t expected_beat(int j, int k);
    prod_t        p;
    int           base;
    int           idx;
    logic [W-1:0] pw;
    for (int c = 0; c < COPIES; c++) begin
      base = (job_max[j] && !job_ones[j]) ? c * UNITS : 0;
      for (int u = 0; u < UNITS; u++) begin
        idx     = base + u + k;
        pw      = (idx < REGS) ? job_row[j][idx] : '0; // zeros come in from the top.
        p[c][u] = {{W{1'b0}}, pw} * {{W{1'b0}}, job_wgt[j][c][u]};
      end
    end
    return p;
  endfunction

  task automatic make_jobs();
    for (int j = 0; j < NUM_JOBS; j++) begin
      job_row[j]   = {$urandom, $urandom, $urandom};
      job_wgt[j]   = {$urandom, $urandom};
      job_shift[j] = $urandom_range(8);
      job_max[j]   = $urandom_range(1);
      job_ones[j]  = ($urandom_range(3) == 0);
      job_lrelu[j] = $urandom_range(1);
      job_duty[j]  = $urandom_range(100, 30);
      job_pgap[j]  = $urandom_range(2);
      job_wgap[j]  = $urandom_range(2);
      for (int k = 0; k <= job_shift[j]; k++) begin
        exp_data.push_back(expected_beat(j, k));
        exp_lrelu.push_back(job_lrelu[j]);
        exp_last.push_back(k == job_shift[j]);
        exp_job.push_back(j);
      end
      total += job_shift[j] + 1;
    end
  endtask

  // ------------------------------
  // failure reporting
  // ------------------------------
  task automatic end_in_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic stop_run(input string what);
    $display("%s", what);
    end_in_failure();
  endtask

  task automatic report_mismatch(input string sig, input logic [127:0] want,
                                 input logic [127:0] got);
    $display("FAILED at %0t: %s expected %0h, got %0h", $time, sig, want, got);
    end_in_failure();
  endtask

  // ------------------------------
  // feeders, sink and monitor
  // ------------------------------
  task automatic feed_pixels();
    int waited;
    for (int j = 0; j < NUM_JOBS; j++) begin
      pix_valid    = 1'b1;
      pix_data     = job_row[j];
      pix_shift    = BITS_SH'(job_shift[j]);
      pix_ones     = job_ones[j];
      pix_is_max   = job_max[j];
      pix_is_lrelu = job_lrelu[j];
      waited       = 0;
      @(posedge aclk);
      while (!pix_ready) begin
        waited++;
        assert (waited < TIMEOUT)
          else stop_run($sformatf("timeout: pixel row of job %0d was never accepted", j));
        @(posedge aclk);
      end
      pix_accepted++;
      #1 pix_valid = 1'b0;
      repeat (job_pgap[j]) begin
        @(posedge aclk);
        #1;
      end
    end
  endtask

  task automatic feed_weights();
    int waited;
    for (int j = 0; j < NUM_JOBS; j++) begin
      wgt_valid  = 1'b1;
      wgt_data   = job_wgt[j];
      wgt_repeat = BITS_SH'(job_shift[j]); // same run length as the pixel side.
      waited     = 0;
      @(posedge aclk);
      while (!wgt_ready) begin
        waited++;
        assert (waited < TIMEOUT)
          else stop_run($sformatf("timeout: weight vector of job %0d was never accepted", j));
        @(posedge aclk);
      end
      #1 wgt_valid = 1'b0;
      repeat (job_wgap[j]) begin
        @(posedge aclk);
        #1;
      end
    end
  endtask

  task automatic drive_out_ready();
    forever begin
      @(posedge aclk);
      #1 out_ready = ($urandom_range(99) < job_duty[cur_job]);
    end
  endtask

  task automatic check_outputs();
    int    waited;
    prod_t want;
    bit    want_lrelu;
    bit    want_last;
    for (int n = 0; n < total; n++) begin
      cur_job = exp_job.pop_front();
      waited  = 0;
      do begin
        @(posedge aclk);
        assert (!out_valid || pix_accepted > 0)
          else stop_run("an output beat appeared before any pixel row was accepted");
        waited++;
        assert (waited <= TIMEOUT)
          else stop_run($sformatf("timeout: output beat %0d never arrived", n));
      end while (!(out_valid && out_ready));
      want       = exp_data.pop_front();
      want_lrelu = exp_lrelu.pop_front();
      want_last  = exp_last.pop_front();
      assert (out_data === want) else report_mismatch("out_data", want, out_data);
      assert (out_is_lrelu === want_lrelu)
        else report_mismatch("out_is_lrelu", want_lrelu, out_is_lrelu);
      assert (out_last === want_last) else report_mismatch("out_last", want_last, out_last);
    end
    repeat (20) begin
      @(posedge aclk);
      assert (!out_valid) else stop_run("an extra output beat followed the last expected one");
    end
  endtask

  initial begin
    aclk         = 1'b0;
    reset        = 1'b1;
    pix_valid    = 1'b0;
    pix_data     = '0;
    pix_shift    = '0;
    pix_ones     = 1'b0;
    pix_is_max   = 1'b0;
    pix_is_lrelu = 1'b0;
    wgt_valid    = 1'b0;
    wgt_data     = '0;
    wgt_repeat   = '0;
    out_ready    = 1'b0;
    pix_accepted = 0;
    cur_job      = 0;
    total        = 0;
    void'($urandom(32'h55d4));
    make_jobs();
    repeat (8) @(posedge aclk);
    assert (!out_valid && !pix_ready && !wgt_ready)
      else stop_run("a ready or out_valid was high during reset");
    #1 reset = 1'b0;
    fork
      drive_out_ready();
    join_none
    fork
      feed_pixels();
      feed_weights();
      check_outputs();
    join
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/conv_front_top.sv
`timescale 1ns/10ps
`default_nettype none

module conv_front_top #(
  parameter int WORD_WIDTH    = conv_front_pkg::DEF_WORD_WIDTH,
  parameter int UNITS         = conv_front_pkg::DEF_UNITS,
  parameter int COPIES        = conv_front_pkg::DEF_COPIES,
  parameter int IM_SHIFT_REGS = conv_front_pkg::DEF_IM_SHIFT_REGS,
  localparam int BITS_SH      = conv_front_pkg::shift_width(IM_SHIFT_REGS)
) (
  input  logic                                         aclk,
  input  logic                                         reset,
  // pixel rows
  input  logic                                         pix_valid,
  output logic                                         pix_ready,
  input  logic [IM_SHIFT_REGS-1:0][WORD_WIDTH-1:0]     pix_data,
  input  logic [BITS_SH-1:0]                           pix_shift,
  input  logic                                         pix_ones,
  input  logic                                         pix_is_max,
  input  logic                                         pix_is_lrelu,
  // weight vectors
  input  logic                                         wgt_valid,
  output logic                                         wgt_ready,
  input  logic [COPIES-1:0][UNITS-1:0][WORD_WIDTH-1:0] wgt_data,
  input  logic [BITS_SH-1:0]                           wgt_repeat,
  // products
  output logic                                         out_valid,
  input  logic                                         out_ready,
  output logic [COPIES-1:0][UNITS-1:0][2*WORD_WIDTH-1:0] out_data,
  output logic                                         out_is_lrelu,
  output logic                                         out_last
);

  import conv_front_pkg::*;

  typedef struct packed {
    logic [COPIES-1:0][UNITS-1:0][WORD_WIDTH-1:0] data;
    pixel_user_t                                  user;
  } pix_beat_t;

  typedef logic [COPIES-1:0][UNITS-1:0][WORD_WIDTH-1:0] wgt_beat_t;

  beat_stream_if #(.payload_t(pix_beat_t)) pix_if ();
  beat_stream_if #(.payload_t(wgt_beat_t)) wgt_if ();

  axis_pixels_shift #(
    .WORD_WIDTH    (WORD_WIDTH),
    .UNITS         (UNITS),
    .COPIES        (COPIES),
    .IM_SHIFT_REGS (IM_SHIFT_REGS),
    .BITS_SH       (BITS_SH)
  ) pixels_i (
    .aclk    (aclk),
    .reset   (reset),
    .s_valid (pix_valid),
    .s_data  (pix_data),
    .s_shift (pix_shift),
    .s_ones  (pix_ones),
    .s_user  (pixel_user_t'{is_max: pix_is_max, is_lrelu: pix_is_lrelu}),
    .s_ready (pix_ready),
    .m       (pix_if)
  );

  weights_replay #(
    .WORD_WIDTH (WORD_WIDTH),
    .UNITS      (UNITS),
    .COPIES     (COPIES),
    .BITS_SH    (BITS_SH)
  ) weights_i (
    .aclk     (aclk),
    .reset    (reset),
    .s_valid  (wgt_valid),
    .s_data   (wgt_data),
    .s_repeat (wgt_repeat),
    .s_ready  (wgt_ready),
    .m        (wgt_if)
  );

  lane_mult_join #(
    .WORD_WIDTH (WORD_WIDTH),
    .UNITS      (UNITS),
    .COPIES     (COPIES)
  ) join_i (
    .aclk       (aclk),
    .reset      (reset),
    .pix        (pix_if),
    .wgt        (wgt_if),
    .m_valid    (out_valid),
    .m_data     (out_data),
    .m_is_lrelu (out_is_lrelu),
    .m_last     (out_last),
    .m_ready    (out_ready)
  );

endmodule

`default_nettype wire

// File: hw/lane_mult_join.sv
`timescale 1ns/10ps
`default_nettype none

module lane_mult_join #(
  parameter int WORD_WIDTH = conv_front_pkg::DEF_WORD_WIDTH,
  parameter int UNITS      = conv_front_pkg::DEF_UNITS,
  parameter int COPIES     = conv_front_pkg::DEF_COPIES
) (
  input  logic                                         aclk,
  input  logic                                         reset,
  beat_stream_if.sink                                  pix,
  beat_stream_if.sink                                  wgt,
  output logic                                         m_valid,
  output logic [COPIES-1:0][UNITS-1:0][2*WORD_WIDTH-1:0] m_data,
  output logic                                         m_is_lrelu,
  output logic                                         m_last,
  input  logic                                         m_ready
);

  import conv_front_pkg::*;

  typedef struct packed {
    logic [COPIES-1:0][UNITS-1:0][WORD_WIDTH-1:0] data;
    pixel_user_t                                  user;
  } pix_beat_t;

  typedef logic [COPIES-1:0][UNITS-1:0][WORD_WIDTH-1:0] wgt_beat_t;

  pix_beat_t pix_beat;
  wgt_beat_t wgt_beat;
  logic      out_free;
  logic      fire;

  assign pix_beat = pix.data;
  assign wgt_beat = wgt.data;

  assign out_free  = m_ready | ~m_valid;
  assign fire      = pix.valid & wgt.valid & out_free; // both sides move together.
  assign pix.ready = fire;
  assign wgt.ready = fire;

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (reset) begin
      m_valid <= 1'b0;
    end else if (out_free) begin
      m_valid <= pix.valid & wgt.valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (fire) begin
      for (int c = 0; c < COPIES; c++) begin
        for (int u = 0; u < UNITS; u++) begin
          m_data[c][u] <= pix_beat.data[c][u] * wgt_beat[c][u];
        end
      end
      m_is_lrelu <= pix_beat.user.is_lrelu;
      m_last     <= pix.last;
    end
  end

  // both producers must end their runs on the same beat.
  assert property (@(posedge aclk) disable iff (reset)
    fire |-> pix.last == wgt.last);

endmodule

`default_nettype wire

// File: hw/weights_replay.sv
`timescale 1ns/10ps
`default_nettype none

module weights_replay #(
  parameter int WORD_WIDTH = conv_front_pkg::DEF_WORD_WIDTH,
  parameter int UNITS      = conv_front_pkg::DEF_UNITS,
  parameter int COPIES     = conv_front_pkg::DEF_COPIES,
  parameter int BITS_SH    = conv_front_pkg::shift_width(conv_front_pkg::DEF_IM_SHIFT_REGS)
) (
  input  logic                                     aclk,
  input  logic                                     reset,
  input  logic                                     s_valid,
  input  logic [COPIES-1:0][UNITS-1:0][WORD_WIDTH-1:0] s_data,
  input  logic [BITS_SH-1:0]                       s_repeat,
  output logic                                     s_ready,
  beat_stream_if.source                            m
);

  typedef logic [COPIES-1:0][UNITS-1:0][WORD_WIDTH-1:0] beat_t;

  logic               clken;
  logic               count_en;
  logic               count_last;
  logic [BITS_SH-1:0] count;
  logic               reg_valid;
  beat_t              reg_data;

  assign count_last = (count == '0);
  assign count_en   = clken & (count_last ? s_valid : 1'b1);
  assign s_ready    = clken & count_last;

  always_ff @(posedge aclk) begin
    if (reset) begin
      count     <= '0;
      reg_valid <= 1'b0;
    end else begin
      if (count_en) begin
        count <= count_last ? s_repeat : count - 1'b1;
      end
      if (s_ready) begin
        reg_valid <= s_valid; // stays up for the whole replay.
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (s_valid & s_ready) begin
      reg_data <= s_data;
    end
  end

  beat_slice #(
    .payload_t (beat_t)
  ) slice_i (
    .aclk     (aclk),
    .reset    (reset),
    .in_valid (reg_valid),
    .in_data  (reg_data),
    .in_last  (count_last),
    .in_ready (clken),
    .out      (m)
  );

endmodule

`default_nettype wire

// File: hw/axis_pixels_shift.sv
`timescale 1ns/10ps
`default_nettype none

module axis_pixels_shift #(
  parameter int WORD_WIDTH    = conv_front_pkg::DEF_WORD_WIDTH,
  parameter int UNITS         = conv_front_pkg::DEF_UNITS,
  parameter int COPIES        = conv_front_pkg::DEF_COPIES,
  parameter int IM_SHIFT_REGS = conv_front_pkg::DEF_IM_SHIFT_REGS,
  parameter int BITS_SH       = conv_front_pkg::shift_width(IM_SHIFT_REGS)
) (
  input  logic                                   aclk,
  input  logic                                   reset,
  input  logic                                   s_valid,
  input  logic [IM_SHIFT_REGS-1:0][WORD_WIDTH-1:0] s_data,
  input  logic [BITS_SH-1:0]                     s_shift,
  input  logic                                   s_ones,
  input  conv_front_pkg::pixel_user_t            s_user,
  output logic                                   s_ready,
  beat_stream_if.source                          m
);

  import conv_front_pkg::*;

  typedef struct packed {
    logic [COPIES-1:0][UNITS-1:0][WORD_WIDTH-1:0] data;
    pixel_user_t                                  user;
  } beat_t;

  logic               clken;
  logic               count_en;
  logic               count_last;
  logic [BITS_SH-1:0] count;

  // ------------------------------
  // countdown over the run
  // ------------------------------
  assign count_last = (count == '0);
  assign count_en   = clken & (count_last ? s_valid : 1'b1);
  assign s_ready    = clken & count_last; // new row only once the run is out.

  logic reg_valid;

  always_ff @(posedge aclk) begin
    if (reset) begin
      count     <= '0;
      reg_valid <= 1'b0;
    end else begin
      if (count_en) begin
        count <= count_last ? s_shift : count - 1'b1;
      end
      if (s_ready) begin
        reg_valid <= s_valid;
      end
    end
  end

  // ------------------------------
  // shift register and side info
  // ------------------------------
  logic [IM_SHIFT_REGS-1:0][WORD_WIDTH-1:0] reg_data;
  pixel_user_t                              reg_user;
  logic                                     reg_ones;

  always_ff @(posedge aclk) begin
    if (count_en) begin
      reg_data <= count_last ? s_data : reg_data >> WORD_WIDTH; // zeros enter at the top.
    end
    if (s_valid & s_ready) begin
      reg_user <= s_user;
      reg_ones <= s_ones;
    end
  end

  // copies broadcast copy 0 unless max pooling asks for its own window.
  logic  per_copy;
  beat_t slice_data;

  assign per_copy = reg_user.is_max & ~reg_ones;

  always_comb begin
    slice_data.user    = reg_user;
    slice_data.data[0] = reg_data[UNITS-1:0];
    for (int c = 1; c < COPIES; c++) begin
      slice_data.data[c] = per_copy ? reg_data[c*UNITS +: UNITS] : reg_data[UNITS-1:0];
    end
  end

  beat_slice #(
    .payload_t (beat_t)
  ) slice_i (
    .aclk     (aclk),
    .reset    (reset),
    .in_valid (reg_valid),
    .in_data  (slice_data),
    .in_last  (count_last), // count at zero holds the final window.
    .in_ready (clken),
    .out      (m)
  );

endmodule

`default_nettype wire

// File: hw/beat_slice.sv
`timescale 1ns/10ps
`default_nettype none

module beat_slice #(
  parameter type payload_t = logic
) (
  input  logic          aclk,
  input  logic          reset,
  input  logic          in_valid,
  input  payload_t      in_data,
  input  logic          in_last,
  output logic          in_ready,
  beat_stream_if.source out
);

  payload_t main_data;
  payload_t skid_data;
  logic     main_last;
  logic     skid_last;
  logic     main_valid;
  logic     skid_valid;
  logic     main_free;

  assign main_free = out.ready | ~main_valid; // output stage moves on this edge.

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge aclk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b0;
    end else if (main_free) begin
      main_valid <= skid_valid | (in_valid & in_ready);
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end else if (in_valid & in_ready) begin
      skid_valid <= 1'b1; // park the beat while the output is stalled.
      in_ready   <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (main_free) begin
      main_data <= skid_valid ? skid_data : in_data;
      main_last <= skid_valid ? skid_last : in_last;
    end
    if (in_ready) begin
      skid_data <= in_data;
      skid_last <= in_last;
    end
  end

  assign out.valid = main_valid;
  assign out.data  = main_data;
  assign out.last  = main_last;

  // an offered beat is held until the slice takes it.
  assert property (@(posedge aclk) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_data) && $stable(in_last));

endmodule

`default_nettype wire

// File: hw/beat_stream_if.sv
`timescale 1ns/10ps
`default_nettype none

// a transfer happens on a cycle where valid and ready are both high.
interface beat_stream_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  payload_t data;
  logic     last;  // final beat of a run.

  modport source (output valid, output data, output last, input ready);

  modport sink (input valid, input data, input last, output ready);

endinterface

`default_nettype wire

// File: hw/conv_front_pkg.sv
`default_nettype none

package conv_front_pkg;

  // side information that rides along with every pixel beat.
  typedef struct packed {
    logic is_max;   // per-copy windows instead of broadcast.
    logic is_lrelu; // passed through to the activation stage.
  } pixel_user_t;

  // ------------------------------
  // default sizes
  // ------------------------------
  localparam int DEF_WORD_WIDTH    = 8;
  localparam int DEF_UNITS         = 4;
  localparam int DEF_COPIES        = 2;
  localparam int DEF_IM_SHIFT_REGS = 12;

  // bits needed to hold a count from 0 up to depth.
  function automatic int shift_width(input int depth);
    int bits;
    bits = (depth < 1) ? 1 : $clog2(depth + 1);
    return bits;
  endfunction

endpackage

`default_nettype wire
